// File: riscv_core.f
+incdir+.
riscv_pkg.sv
fetch_unit.sv
sync_ram.sv
decoder.sv
reg_file.sv
execute.sv
writeback.sv
riscv_core.sv
tb_riscv_core.sv

// File: Makefile
VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = tb_riscv_core
FILELIST  = riscv_core.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "ALL TESTS PASSED"

clean:
	rm -rf obj_dir

// File: tb_riscv_core.sv
`default_nettype none
`timescale 1ns/100ps

`include "riscv_macros.svh"

module tb_riscv_core;

    localparam int          N_RANDOM  = 200;
    localparam int          MAX_WORDS = 256;
    localparam int          TIMEOUT   = 3 * 250 + 50;
    localparam logic [31:0] DATA_BASE = 32'h0000_1000;   // x8 after lui x8, 1
    localparam logic [31:0] JAL_SELF  = 32'h0000_006f;   // jal x0, 0
    localparam logic [6:0]  OP_LUI    = 7'b0110111;
    localparam logic [6:0]  OP_JAL    = 7'b1101111;
    localparam logic [6:0]  OP_BRANCH = 7'b1100011;
    localparam logic [6:0]  OP_LOAD   = 7'b0000011;
    localparam logic [6:0]  OP_STORE  = 7'b0100011;
    localparam logic [6:0]  OP_IMM    = 7'b0010011;
    localparam logic [6:0]  OP_REG    = 7'b0110011;
    localparam logic [6:0]  OP_SYSTEM = 7'b1110011;

    logic                    clk;
    logic                    rst_i;
    logic                    imem_we_i;
    logic [`IMEM_AWIDTH-1:0] imem_waddr_i;
    logic [`XLEN-1:0]        imem_wdata_i;
    wire  [`XLEN-1:0]        csr_o;
    wire                     csr_wr_o;

    logic [31:0] prog [MAX_WORDS];
    int          prog_len;
    logic [31:0] exp_q [$];
    logic [31:0] exp_val;
    int          exp_total;
    int          seed;
    int          cycles;
    int          pulses;
    int          value_errors;     // counted by the csr checker
    int          extra_writes;
    int          end_errors;       // counted by the main sequence
    bit          running;

    riscv_core riscv_core_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .imem_we_i    (imem_we_i),
        .imem_waddr_i (imem_waddr_i),
        .imem_wdata_i (imem_wdata_i),
        .csr_o        (csr_o),
        .csr_wr_o     (csr_wr_o)
    );

    initial clk = 1'b0;
    always #4 clk = ~clk;   // 8 ns period

    function automatic int pick(input int n);
        return $unsigned($random(seed)) % n;
    endfunction

    // operand registers stay in x1..x7, x8 holds the data base
    function automatic logic [4:0] reg_pick();
        return 5'(1 + pick(7));
    endfunction

    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3,
                                           input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, OP_REG};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], OP_STORE};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OP_BRANCH};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OP_JAL};
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[prog_len] = word;
        prog_len++;
    endtask

    task automatic gen_program();
        int          kind;
        int          skip;
        logic [2:0]  f3;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [5:0]  mask;
        logic [11:0] imm;
        emit({20'h00001, 5'd8, OP_LUI});
        for (int k = 0; k < 16; k++) begin
            emit(s_type(12'(4 * k), 5'd0, 5'd8, 3'b010));   // clear the data region
        end
        for (int k = 1; k < 8; k++) begin
            emit({20'($random(seed)), 5'(k), OP_LUI});
            emit(i_type(12'($random(seed)), 5'(k), 3'b000, 5'(k), OP_IMM));
        end
        for (int i = 0; i < N_RANDOM; i++) begin
            kind = (i % 4 == 3) ? 7 : pick(7);
            if ((kind == 5 || kind == 6) && i >= N_RANDOM - 3) begin
                kind = 0;   // keep forward targets inside the program
            end
            f3 = 3'(pick(8));
            case (kind)
                0: emit(r_type(((f3 == 3'd0 || f3 == 3'd5) && pick(2) == 1) ? 7'h20 : 7'h00,
                               reg_pick(), reg_pick(), f3, reg_pick()));
                1: begin
                    imm = 12'($random(seed));
                    if (f3 == 3'd1) begin
                        imm = {7'h00, 5'(pick(32))};
                    end else if (f3 == 3'd5) begin
                        imm = {(pick(2) == 1) ? 7'h20 : 7'h00, 5'(pick(32))};
                    end
                    emit(i_type(imm, reg_pick(), f3, reg_pick(), OP_IMM));
                end
                2: emit({20'($random(seed)), reg_pick(), OP_LUI});
                3: begin
                    case (pick(5))
                        0:       f3 = 3'd0;
                        1:       f3 = 3'd1;
                        2:       f3 = 3'd2;
                        3:       f3 = 3'd4;
                        default: f3 = 3'd5;
                    endcase
                    mask = (f3[1:0] == 2'd0) ? 6'h3f : (f3[1:0] == 2'd1) ? 6'h3e : 6'h3c;
                    emit(i_type({6'b0, 6'(pick(64)) & mask}, 5'd8, f3, reg_pick(), OP_LOAD));
                end
                4: begin
                    f3   = 3'(pick(3));
                    mask = (f3 == 3'd0) ? 6'h3f : (f3 == 3'd1) ? 6'h3e : 6'h3c;
                    emit(s_type({6'b0, 6'(pick(64)) & mask}, reg_pick(), 5'd8, f3));
                end
                5: begin
                    rs1  = reg_pick();
                    rs2  = (pick(3) == 0) ? rs1 : reg_pick();   // equal regs force beq taken
                    skip = 1 + pick(3);
                    emit(b_type(13'(4 * (skip + 1)), rs2, rs1, 3'(pick(2))));
                end
                6: begin
                    skip = 1 + pick(3);
                    emit(j_type(21'(4 * (skip + 1)), 5'(pick(8))));
                end
                default: begin
                    if (pick(2) == 1) begin
                        emit(i_type(`CSR_ADDR, reg_pick(), 3'b001, reg_pick(), OP_SYSTEM));
                    end else begin
                        emit(i_type(`CSR_ADDR, 5'(pick(32)), 3'b101, reg_pick(), OP_SYSTEM));
                    end
                end
            endcase
        end
        for (int k = 1; k < 8; k++) begin
            emit(i_type(`CSR_ADDR, 5'(k), 3'b001, 5'd0, OP_SYSTEM));   // register dump
        end
        emit(JAL_SELF);
    endtask

    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            3'd0:    r = alt ? a - b : a + b;
            3'd1:    r = a << b[4:0];
            3'd2:    r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3:    r = (a < b) ? 32'd1 : 32'd0;
            3'd4:    r = a ^ b;
            3'd5: begin
                if (alt) begin
                    r = $signed(a) >>> b[4:0];
                end else begin
                    r = a >> b[4:0];
                end
            end
            3'd6:    r = a | b;
            default: r = a & b;
        endcase
        return r;
    endfunction

    // instruction level model, fills the expected csr queue
    task automatic run_reference();
        logic [31:0] x [32];
        logic [7:0]  dm [64];
        logic [31:0] pc;
        logic [31:0] ins;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [5:0]  o;
        logic [4:0]  rd;
        logic [2:0]  f3;
        int          steps;
        for (int k = 0; k < 32; k++) begin
            x[k] = '0;
        end
        for (int k = 0; k < 64; k++) begin
            dm[k] = '0;
        end
        pc    = '0;
        steps = 0;
        while (prog[pc[9:2]] != JAL_SELF && steps < 1000) begin
            ins = prog[pc[9:2]];
            rd  = ins[11:7];
            f3  = ins[14:12];
            a   = x[ins[19:15]];
            b   = x[ins[24:20]];
            pc  = pc + 32'd4;
            case (ins[6:0])
                OP_LUI:    x[rd] = {ins[31:12], 12'b0};
                OP_JAL: begin
                    x[rd] = pc;
                    pc    = pc - 32'd4 + {{11{ins[31]}}, ins[31], ins[19:12], ins[20],
                                          ins[30:21], 1'b0};
                end
                OP_BRANCH: begin
                    if ((f3 == 3'b000) ? (a == b) : (a != b)) begin
                        pc = pc - 32'd4 + {{19{ins[31]}}, ins[31], ins[7], ins[30:25],
                                           ins[11:8], 1'b0};
                    end
                end
                OP_LOAD: begin
                    addr = a + {{20{ins[31]}}, ins[31:20]} - DATA_BASE;
                    o    = addr[5:0];
                    case (f3)
                        3'd0:    x[rd] = {{24{dm[o][7]}}, dm[o]};
                        3'd1:    x[rd] = {{16{dm[o + 6'd1][7]}}, dm[o + 6'd1], dm[o]};
                        3'd4:    x[rd] = {24'b0, dm[o]};
                        3'd5:    x[rd] = {16'b0, dm[o + 6'd1], dm[o]};
                        default: x[rd] = {dm[o + 6'd3], dm[o + 6'd2], dm[o + 6'd1], dm[o]};
                    endcase
                end
                OP_STORE: begin
                    addr  = a + {{20{ins[31]}}, ins[31:25], ins[11:7]} - DATA_BASE;
                    o     = addr[5:0];
                    dm[o] = b[7:0];
                    if (f3 != 3'd0) begin
                        dm[o + 6'd1] = b[15:8];
                    end
                    if (f3 == 3'd2) begin
                        dm[o + 6'd2] = b[23:16];
                        dm[o + 6'd3] = b[31:24];
                    end
                end
                OP_IMM:    x[rd] = alu_model(f3, f3 == 3'd5 && ins[30],
                                             a, {{20{ins[31]}}, ins[31:20]});
                OP_REG:    x[rd] = alu_model(f3, ins[30], a, b);
                OP_SYSTEM: begin
                    if (ins[31:20] == `CSR_ADDR && f3[1:0] == 2'b01) begin
                        exp_q.push_back(f3[2] ? {27'b0, ins[19:15]} : a);   // rd untouched
                    end
                end
                default: ;
            endcase
            x[0] = '0;
            steps++;
        end
    endtask

    // host load port, only while reset is held
    task automatic load_program();
        for (int k = 0; k < prog_len; k++) begin
            @(posedge clk);
            imem_we_i    <= 1'b1;
            imem_waddr_i <= k[`IMEM_AWIDTH-1:0];
            imem_wdata_i <= prog[k];
        end
        @(posedge clk);
        imem_we_i <= 1'b0;
        repeat (3) @(posedge clk);
        rst_i <= 1'b0;
    endtask

    // strobe is registered, so the middle of the cycle is stable
    always @(negedge clk) begin
        if (running && csr_wr_o) begin
            pulses++;
            assert (exp_q.size() > 0) else begin
                $display("unexpected csr write at %0t with csr_o %h", $time, csr_o);
                extra_writes++;
            end
            if (exp_q.size() > 0) begin
                exp_val = exp_q.pop_front();
                assert (csr_o == exp_val) else begin
                    $display("mismatch at %0t: csr_o expected %h got %h", $time, exp_val, csr_o);
                    value_errors++;
                end
            end
        end
    end

    initial begin
        seed         = 32'h64aa_da02;
        rst_i        = 1'b1;
        imem_we_i    = 1'b0;
        imem_waddr_i = '0;
        imem_wdata_i = '0;
        running      = 1'b0;
        cycles       = 0;
        pulses       = 0;
        value_errors = 0;
        extra_writes = 0;
        end_errors   = 0;
        prog_len     = 0;
        gen_program();
        run_reference();
        exp_total = exp_q.size();
        load_program();
        running = 1'b1;
        @(negedge clk);
        assert (csr_o == '0) else begin
            $display("mismatch at %0t: csr_o expected 0 got %h", $time, csr_o);
            end_errors++;
        end
        assert (csr_wr_o == 1'b0) else begin
            $display("mismatch at %0t: csr_wr_o expected 0 got %b", $time, csr_wr_o);
            end_errors++;
        end
        while (exp_q.size() > 0 && cycles < TIMEOUT) begin
            @(posedge clk);
            cycles++;
        end
        if (exp_q.size() == 0) begin
            repeat (20) @(posedge clk);   // self loop must stay quiet
        end
        assert (exp_q.size() == 0) else begin
            $display("timeout after %0d cycles, %0d expected csr writes never arrived",
                     cycles, exp_q.size());
            end_errors++;
        end
        assert (pulses == exp_total) else begin
            $display("mismatch at %0t: csr_wr_o pulse count expected %0d got %0d",
                     $time, exp_total, pulses);
            end_errors++;
        end
        $display("error counts: csr value %0d, extra csr writes %0d, end of run %0d",
                 value_errors, extra_writes, end_errors);
        if (value_errors == 0 && extra_writes == 0 && end_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: riscv_core.sv
`default_nettype none
`timescale 1ns/100ps

`include "riscv_macros.svh"

module riscv_core import riscv_pkg::*; (
    input  wire                    clk,
    input  wire                    rst_i,
    input  wire                    imem_we_i,     // host loader, only during reset
    input  wire [`IMEM_AWIDTH-1:0] imem_waddr_i,
    input  wire [`XLEN-1:0]        imem_wdata_i,
    output logic [`XLEN-1:0]       csr_o,
    output logic                   csr_wr_o
);

    logic [`XLEN-1:0]       pc_next;
    logic [`XLEN-1:0]       pc;
    logic                   if_valid;
    logic [`XLEN-1:0]       inst;

    logic [4:0]             rs1_addr;
    logic [4:0]             rs2_addr;
    logic [`XLEN-1:0]       rs1_data;
    logic [`XLEN-1:0]       rs2_data;
    id_ex_t                 id_ex;

    logic                   redirect;
    logic [`XLEN-1:0]       target;
    logic [`DMEM_AWIDTH-1:0] dmem_addr;
    logic [3:0]             dmem_wbe;
    logic [`XLEN-1:0]       dmem_wdata;
    logic [`XLEN-1:0]       dmem_rdata;
    ex_wb_t                 ex_wb;
    wb_t                    wb;

    fetch_unit fetch_unit_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .redirect_i (redirect),
        .target_i   (target),
        .pc_next_o  (pc_next),
        .pc_o       (pc),
        .if_valid_o (if_valid)
    );

    // port 0 fetches, port 1 is the host loader
    sync_ram #(.AWIDTH(`IMEM_AWIDTH)) imem (
        .clk     (clk),
        .addr0_i (pc_next[`IMEM_AWIDTH+1:2]),
        .wbe0_i  (4'b0000),
        .d0_i    ('0),
        .q0_o    (inst),
        .addr1_i (imem_waddr_i),
        .we1_i   (imem_we_i),
        .d1_i    (imem_wdata_i)
    );

    decoder decoder_inst (
        .clk        (clk),
        .rst_i      (rst_i),
        .inst_i     (inst),
        .pc_i       (pc),
        .if_valid_i (if_valid),
        .kill_i     (redirect),
        .rs1_addr_o (rs1_addr),
        .rs2_addr_o (rs2_addr),
        .rs1_data_i (rs1_data),
        .rs2_data_i (rs2_data),
        .id_ex_o    (id_ex)
    );

    reg_file reg_file_inst (
        .clk   (clk),
        .ra1_i (rs1_addr),
        .ra2_i (rs2_addr),
        .rd1_o (rs1_data),
        .rd2_o (rs2_data),
        .wb_i  (wb)
    );

    execute execute_inst (
        .clk          (clk),
        .rst_i        (rst_i),
        .id_ex_i      (id_ex),
        .wb_i         (wb),
        .redirect_o   (redirect),
        .target_o     (target),
        .dmem_addr_o  (dmem_addr),
        .dmem_wbe_o   (dmem_wbe),
        .dmem_wdata_o (dmem_wdata),
        .ex_wb_o      (ex_wb),
        .csr_o        (csr_o),
        .csr_wr_o     (csr_wr_o)
    );

    // second port unused on the data side
    sync_ram #(.AWIDTH(`DMEM_AWIDTH)) dmem (
        .clk     (clk),
        .addr0_i (dmem_addr),
        .wbe0_i  (dmem_wbe),
        .d0_i    (dmem_wdata),
        .q0_o    (dmem_rdata),
        .addr1_i ('0),
        .we1_i   (1'b0),
        .d1_i    ('0)
    );

    writeback writeback_inst (
        .ex_wb_i      (ex_wb),
        .dmem_rdata_i (dmem_rdata),
        .wb_o         (wb)
    );

endmodule

`default_nettype wire

// File: writeback.sv
`default_nettype none
`timescale 1ns/100ps

`include "riscv_macros.svh"

module writeback import riscv_pkg::*; (
    input  wire ex_wb_t     ex_wb_i,
    input  wire [`XLEN-1:0] dmem_rdata_i,
    output wb_t             wb_o
);

    logic [`XLEN-1:0] shifted;
    logic [`XLEN-1:0] load_data;

    // addressed byte or half moved down to bit 0
    assign shifted = dmem_rdata_i >> {ex_wb_i.byte_off, 3'b000};

    always_comb begin
        case (ex_wb_i.mem_size)
            MEM_BYTE: load_data = ex_wb_i.load_unsigned ? {24'b0, shifted[7:0]} :
                                  {{24{shifted[7]}}, shifted[7:0]};
            MEM_HALF: load_data = ex_wb_i.load_unsigned ? {16'b0, shifted[15:0]} :
                                  {{16{shifted[15]}}, shifted[15:0]};
            default:  load_data = dmem_rdata_i;
        endcase
    end

    always_comb begin
        wb_o.we   = ex_wb_i.valid & ex_wb_i.reg_write;
        wb_o.addr = ex_wb_i.rd;
        case (ex_wb_i.wb_sel)
            WB_LOAD:     wb_o.data = load_data;
            WB_PC_PLUS4: wb_o.data = ex_wb_i.pc_plus4;
            default:     wb_o.data = ex_wb_i.result;
        endcase
    end

endmodule

`default_nettype wire

// File: execute.sv
`default_nettype none
`timescale 1ns/100ps

`include "riscv_macros.svh"

module execute import riscv_pkg::*; (
    input  wire                     clk,
    input  wire                     rst_i,
    input  wire id_ex_t             id_ex_i,
    input  wire wb_t                wb_i,
    output logic                    redirect_o,
    output logic [`XLEN-1:0]        target_o,
    output logic [`DMEM_AWIDTH-1:0] dmem_addr_o,
    output logic [3:0]              dmem_wbe_o,
    output logic [`XLEN-1:0]        dmem_wdata_o,
    output ex_wb_t                  ex_wb_o,
    output logic [`XLEN-1:0]        csr_o,
    output logic                    csr_wr_o
);

    ctrl_t            ctrl;
    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] rs2_fwd;
    logic [`XLEN-1:0] op_b;
    logic [`XLEN-1:0] alu_res;
    logic [1:0]       byte_off;
    logic             taken;
    logic [`XLEN-1:0] csr_q;
    logic             csr_wr_q;
    ex_wb_t           ex_wb_q;

    assign ctrl = id_ex_i.ctrl;

    // bypass from write back, x0 never forwarded
    assign op_a = (wb_i.we && wb_i.addr != 5'd0 && wb_i.addr == id_ex_i.rs1_addr) ?
                  wb_i.data : id_ex_i.rs1_data;
    assign rs2_fwd = (wb_i.we && wb_i.addr != 5'd0 && wb_i.addr == id_ex_i.rs2_addr) ?
                     wb_i.data : id_ex_i.rs2_data;
    assign op_b = ctrl.src_b_imm ? id_ex_i.imm : rs2_fwd;

    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_res = op_a + op_b;
            ALU_SUB:    alu_res = op_a - op_b;
            ALU_AND:    alu_res = op_a & op_b;
            ALU_OR:     alu_res = op_a | op_b;
            ALU_XOR:    alu_res = op_a ^ op_b;
            ALU_SLL:    alu_res = op_a << op_b[4:0];
            ALU_SRL:    alu_res = op_a >> op_b[4:0];
            ALU_SRA:    alu_res = $signed(op_a) >>> op_b[4:0];
            ALU_SLT:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_res = {31'b0, op_a < op_b};
            default:    alu_res = op_b;     // PASS_B
        endcase
    end

    // branch compare on the forwarded register values
    always_comb begin
        case (ctrl.branch)
            BR_BEQ:  taken = (op_a == rs2_fwd);
            BR_BNE:  taken = (op_a != rs2_fwd);
            BR_JAL:  taken = 1'b1;
            default: taken = 1'b0;
        endcase
    end

    assign redirect_o = id_ex_i.valid & taken;
    assign target_o   = id_ex_i.pc + id_ex_i.imm;

    assign byte_off    = alu_res[1:0];
    assign dmem_addr_o = alu_res[`DMEM_AWIDTH+1:2];

    // replicate store data across lanes, enables pick the live ones
    always_comb begin
        case (ctrl.mem_size)
            MEM_BYTE: begin
                dmem_wdata_o = {4{rs2_fwd[7:0]}};
                dmem_wbe_o   = 4'b0001 << byte_off;
            end
            MEM_HALF: begin
                dmem_wdata_o = {2{rs2_fwd[15:0]}};
                dmem_wbe_o   = 4'b0011 << {byte_off[1], 1'b0};
            end
            default: begin
                dmem_wdata_o = rs2_fwd;
                dmem_wbe_o   = 4'b1111;
            end
        endcase
        if (!(id_ex_i.valid && ctrl.mem_write)) begin
            dmem_wbe_o = 4'b0000;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            csr_q    <= '0;
            csr_wr_q <= 1'b0;
        end else begin
            csr_wr_q <= id_ex_i.valid & ctrl.csr_write;   // one cycle strobe
            if (id_ex_i.valid && ctrl.csr_write) begin
                csr_q <= ctrl.csr_imm ? id_ex_i.imm : op_a;
            end
        end
    end

    assign csr_o    = csr_q;
    assign csr_wr_o = csr_wr_q;

    always_ff @(posedge clk) begin
        ex_wb_q.valid         <= id_ex_i.valid & ~rst_i;
        ex_wb_q.rd            <= id_ex_i.rd;
        ex_wb_q.result        <= alu_res;
        ex_wb_q.pc_plus4      <= id_ex_i.pc + 32'd4;   // JAL link
        ex_wb_q.byte_off      <= byte_off;
        ex_wb_q.mem_size      <= ctrl.mem_size;
        ex_wb_q.load_unsigned <= ctrl.load_unsigned;
        ex_wb_q.reg_write     <= ctrl.reg_write;
        ex_wb_q.wb_sel        <= ctrl.mem_read ? WB_LOAD : ctrl.wb_sel;
    end

    assign ex_wb_o = ex_wb_q;

endmodule

`default_nettype wire

// File: reg_file.sv
`default_nettype none
`timescale 1ns/100ps

`include "riscv_macros.svh"

module reg_file import riscv_pkg::*; (
    input  wire              clk,
    input  wire [4:0]        ra1_i,
    input  wire [4:0]        ra2_i,
    output logic [`XLEN-1:0] rd1_o,
    output logic [`XLEN-1:0] rd2_o,
    input  wire wb_t         wb_i
);

    logic [`XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (wb_i.we && wb_i.addr != 5'd0) begin
            regs[wb_i.addr] <= wb_i.data;
        end
    end

    // write-through so decode sees the value written this cycle
    assign rd1_o = (ra1_i == 5'd0) ? '0 :
                   (wb_i.we && wb_i.addr == ra1_i) ? wb_i.data : regs[ra1_i];
    assign rd2_o = (ra2_i == 5'd0) ? '0 :
                   (wb_i.we && wb_i.addr == ra2_i) ? wb_i.data : regs[ra2_i];

endmodule

`default_nettype wire

// File: decoder.sv
`default_nettype none
`timescale 1ns/100ps

`include "riscv_macros.svh"

module decoder import riscv_pkg::*; (
    input  wire              clk,
    input  wire              rst_i,
    input  wire [`XLEN-1:0]  inst_i,
    input  wire [`XLEN-1:0]  pc_i,
    input  wire              if_valid_i,
    input  wire              kill_i,
    output logic [4:0]       rs1_addr_o,
    output logic [4:0]       rs2_addr_o,
    input  wire [`XLEN-1:0]  rs1_data_i,
    input  wire [`XLEN-1:0]  rs2_data_i,
    output id_ex_t           id_ex_o
);

    logic [2:0]       funct3;
    ctrl_t            ctrl;
    logic [`XLEN-1:0] imm;
    id_ex_t           id_ex_q;

    // sub only for the register form but sra for both
    function automatic alu_op_e alu_decode(input logic [2:0] f3, input logic alt,
                                           input logic is_op);
        case (f3)
            3'b000:  return (is_op && alt) ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return alt ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign funct3     = inst_i[14:12];
    assign rs1_addr_o = inst_i[19:15];
    assign rs2_addr_o = inst_i[24:20];

    always_comb begin
        ctrl = '0;                                  // no-op by default
        imm  = {{20{inst_i[31]}}, inst_i[31:20]};   // I type
        case (inst_i[6:0])
            OPC_LUI: begin
                imm            = {inst_i[31:12], 12'b0};
                ctrl.alu_op    = ALU_PASS_B;
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_JAL: begin
                imm            = {{11{inst_i[31]}}, inst_i[31], inst_i[19:12],
                                  inst_i[20], inst_i[30:21], 1'b0};
                ctrl.branch    = BR_JAL;
                ctrl.reg_write = 1'b1;
                ctrl.wb_sel    = WB_PC_PLUS4;
            end
            OPC_BRANCH: begin
                imm = {{19{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25],
                       inst_i[11:8], 1'b0};
                if (funct3 == 3'b000) begin
                    ctrl.branch = BR_BEQ;
                end else if (funct3 == 3'b001) begin
                    ctrl.branch = BR_BNE;
                end
            end
            OPC_LOAD: begin
                if (funct3[1:0] != 2'b11 && funct3 != 3'b110) begin
                    ctrl.src_b_imm     = 1'b1;
                    ctrl.mem_read      = 1'b1;
                    ctrl.mem_size      = mem_size_e'(funct3[1:0]);
                    ctrl.load_unsigned = funct3[2];
                    ctrl.reg_write     = 1'b1;
                end
            end
            OPC_STORE: begin
                imm = {{20{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
                if (funct3[1:0] != 2'b11 && funct3[2] == 1'b0) begin
                    ctrl.src_b_imm = 1'b1;
                    ctrl.mem_write = 1'b1;
                    ctrl.mem_size  = mem_size_e'(funct3[1:0]);
                end
            end
            OPC_OP_IMM: begin
                ctrl.alu_op    = alu_decode(funct3, inst_i[30], 1'b0);
                ctrl.src_b_imm = 1'b1;
                ctrl.reg_write = 1'b1;
            end
            OPC_OP: begin
                ctrl.alu_op    = alu_decode(funct3, inst_i[30], 1'b1);
                ctrl.reg_write = 1'b1;
            end
            OPC_SYSTEM: begin
                imm = {27'b0, inst_i[19:15]};       // zimm for CSRRWI
                if (inst_i[31:20] == `CSR_ADDR && funct3[1:0] == 2'b01) begin
                    ctrl.csr_write = 1'b1;
                    ctrl.csr_imm   = funct3[2];
                end
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        id_ex_q.pc       <= pc_i;
        id_ex_q.rs1_data <= rs1_data_i;
        id_ex_q.rs2_data <= rs2_data_i;
        id_ex_q.rs1_addr <= rs1_addr_o;
        id_ex_q.rs2_addr <= rs2_addr_o;
        id_ex_q.rd       <= inst_i[11:7];
        id_ex_q.imm      <= imm;
        id_ex_q.ctrl     <= ctrl;
        // bubble on reset, on a kill from execute or with no fetched word
        id_ex_q.valid    <= ~(rst_i | kill_i | ~if_valid_i);
    end

    assign id_ex_o = id_ex_q;

endmodule

`default_nettype wire

// File: sync_ram.sv
`default_nettype none
`timescale 1ns/100ps

`include "riscv_macros.svh"

module sync_ram #(
    parameter int AWIDTH = 10
) (
    input  wire              clk,
    input  wire [AWIDTH-1:0] addr0_i,
    input  wire [3:0]        wbe0_i,    // per byte lane
    input  wire [`XLEN-1:0]  d0_i,
    output logic [`XLEN-1:0] q0_o,
    input  wire [AWIDTH-1:0] addr1_i,
    input  wire              we1_i,
    input  wire [`XLEN-1:0]  d1_i
);

    logic [`XLEN-1:0] mem [2**AWIDTH];

    always_ff @(posedge clk) begin
        q0_o <= mem[addr0_i];       // read returns old data on a same-address write
        for (int i = 0; i < 4; i++) begin
            if (wbe0_i[i]) begin
                mem[addr0_i][8*i +: 8] <= d0_i[8*i +: 8];
            end
        end
        if (we1_i) begin
            mem[addr1_i] <= d1_i;   // whole word
        end
    end

endmodule

`default_nettype wire

// File: fetch_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "riscv_macros.svh"

module fetch_unit (
    input  wire              clk,
    input  wire              rst_i,
    input  wire              redirect_i,
    input  wire [`XLEN-1:0]  target_i,
    output logic [`XLEN-1:0] pc_next_o,   // imem read address
    output logic [`XLEN-1:0] pc_o,
    output logic             if_valid_o
);

    logic [`XLEN-1:0] pc_q;

    always_comb begin
        if (rst_i) begin
            pc_next_o = `RESET_PC;
        end else if (redirect_i) begin
            pc_next_o = target_i;       // target word arrives next cycle
        end else begin
            pc_next_o = pc_q + 32'd4;
        end
    end

    // tracks the address of the word now leaving imem
    always_ff @(posedge clk) begin
        pc_q <= pc_next_o;
    end

    assign pc_o = pc_q;

    // no usable word during reset or while execute redirects
    assign if_valid_o = ~rst_i & ~redirect_i;

endmodule

`default_nettype wire

// File: riscv_pkg.sv
`default_nettype none

`include "riscv_macros.svh"

package riscv_pkg;

    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_JAL    = 7'b1101111,
        OPC_BRANCH = 7'b1100011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
        ALU_PASS_B      // LUI
    } alu_op_e;

    typedef enum logic [1:0] {BR_NONE, BR_BEQ, BR_BNE, BR_JAL} branch_e;

    // encoding follows funct3[1:0] of loads and stores
    typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;

    typedef enum logic [1:0] {WB_ALU, WB_LOAD, WB_PC_PLUS4} wb_sel_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      src_b_imm;      // operand b from immediate
        branch_e   branch;
        logic      mem_read;
        logic      mem_write;
        mem_size_e mem_size;
        logic      load_unsigned;
        logic      reg_write;
        wb_sel_e   wb_sel;
        logic      csr_write;
        logic      csr_imm;        // CSRRWI, value in imm
    } ctrl_t;

    typedef struct packed {
        logic             valid;
        logic [`XLEN-1:0] pc;
        logic [`XLEN-1:0] rs1_data;
        logic [`XLEN-1:0] rs2_data;
        logic [4:0]       rs1_addr;
        logic [4:0]       rs2_addr;
        logic [4:0]       rd;
        logic [`XLEN-1:0] imm;
        ctrl_t            ctrl;
    } id_ex_t;

    typedef struct packed {
        logic             valid;
        logic [4:0]       rd;
        logic [`XLEN-1:0] result;
        logic [`XLEN-1:0] pc_plus4;
        logic [1:0]       byte_off;    // low address bits for load lane select
        mem_size_e        mem_size;
        logic             load_unsigned;
        logic             reg_write;
        wb_sel_e          wb_sel;
    } ex_wb_t;

    typedef struct packed {
        logic             we;
        logic [4:0]       addr;
        logic [`XLEN-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

// File: riscv_macros.svh
`ifndef RISCV_MACROS_SVH
`define RISCV_MACROS_SVH

// datapath width
`define XLEN        32

// first fetch address after reset
`define RESET_PC    32'h0000_0000

// word address widths of the two memories
`define IMEM_AWIDTH 10
`define DMEM_AWIDTH 10

// the only CSR this core implements
`define CSR_ADDR    12'h51e

`endif
